// ==== build.f ====
+incdir+design
design/xosera_pkg.sv
design/bus_regs.sv
design/video_timing.sv
design/vram_arb.sv
design/pixel_out.sv
design/intr_ctrl.sv
design/xosera_top.sv
tb/xosera_properties.sv
tb/xosera_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator, the log decides the result
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module xosera_tb \
    -o xosera_sim > sim.log 2>&1 &&
./obj_dir/xosera_sim +verilator+error+limit+100 >> sim.log 2>&1
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1
grep -q "=== PASS ===" sim.log || exit 1
exit 0

// ==== tb/xosera_tb.sv ====
/*
 * testbench for the display controller top
 * VRAM and palette models start cleared, like the DUT arrays
 * run is bounded to 20 frames of H_TOTAL*V_TOTAL clocks
 */
`include "xosera_macros.svh"

module xosera_tb import xosera_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_CYCLES    = `H_TOTAL * `V_TOTAL;
    localparam int WATCHDOG_FRAMES = 20;
    localparam int RW_WORDS        = 8;                 // write/read-back test length
    localparam int FRAME_WORDS     = `H_VIS * `V_VIS;
    localparam logic [3:0] R_VADDR = 4'(`REG_VRAM_ADDR);
    localparam logic [3:0] R_VDATA = 4'(`REG_VRAM_DATA);
    localparam logic [3:0] R_PAL   = 4'(`REG_PAL_DATA);
    localparam logic [3:0] R_INT   = 4'(`REG_INT_CTRL);
    localparam logic [3:0] R_STAT  = 4'(`REG_STATUS);

    logic           clk, reset_i;
    logic           bus_cs_n_i, bus_rd_nwr_i, bus_bytesel_i;
    logic [3:0]     bus_reg_num_i;
    logic [7:0]     bus_data_i, bus_data_o;
    logic           bus_intr_o, hsync_o, vsync_o, dv_de_o;
    logic [3:0]     red_o, green_o, blue_o;

    word_t          vram_model [0:2**`VRAM_AW-1];
    rgb_t           pal_model [0:`PAL_N-1];
    logic [31:0]    rng = 32'h1e32;
    int unsigned    strobe_count = 0;                   // bus_intr_o pulses seen

    xosera_top xosera_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // strobe counter, samples before the edge updates
    always @(posedge clk) begin
        if (bus_intr_o) begin
            strobe_count <= strobe_count + 1;
        end
    end

    always @(negedge clk) begin
        if (xosera_top_inst.xosera_properties_inst.prop_failed) begin
            stop_run("a bound property on the DUT outputs failed");
        end
    end

    initial begin
        repeat (WATCHDOG_FRAMES * FRAME_CYCLES) @(posedge clk);
        stop_run("watchdog expired before the tests finished");
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t next_word();
        rng = xorshift32(rng);
        return rng[15:0];
    endfunction

    task automatic stop_run(input string why);
        $display("=== FAIL ===");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string test, input int unsigned expected,
                               input int unsigned actual);
        assert (expected == actual) else begin
            $display("Fail %s: expected %0h, actual %0h", test, expected, actual);
            stop_run("value mismatch");
        end
    endtask

    // one cs low cycle, then cs high for a cycle
    task automatic bus_write(input logic [3:0] reg_num, input logic odd, input logic [7:0] data);
        @(posedge clk);
        bus_cs_n_i    <= 1'b0;
        bus_rd_nwr_i  <= 1'b0;
        bus_reg_num_i <= reg_num;
        bus_bytesel_i <= odd;
        bus_data_i    <= data;
        @(posedge clk);
        bus_cs_n_i    <= 1'b1;
    endtask

    task automatic bus_read(input logic [3:0] reg_num, input logic odd, output logic [7:0] data);
        @(posedge clk);
        bus_cs_n_i    <= 1'b0;
        bus_rd_nwr_i  <= 1'b1;
        bus_reg_num_i <= reg_num;
        bus_bytesel_i <= odd;
        @(posedge clk);
        bus_cs_n_i    <= 1'b1;
        @(negedge clk);
        data = bus_data_o;          // registered on the edge above
    endtask

    task automatic write_word(input logic [3:0] reg_num, input word_t w);
        bus_write(reg_num, 1'b0, w[15:8]);
        bus_write(reg_num, 1'b1, w[7:0]);     // odd byte commits
    endtask

    task automatic wait_idle();
        logic [7:0] st;
        for (int i = 0; i < 64; i++) begin
            bus_read(R_STAT, 1'b1, st);
            if (!st[2]) return;
        end
        stop_run("VRAM access still busy after 64 status polls");
    endtask

    task automatic wait_vsync_fall();
        logic vs_q;
        vs_q = 1'b0;
        for (int i = 0; i < 2 * FRAME_CYCLES; i++) begin
            @(negedge clk);
            if (vs_q && !vsync_o) return;
            vs_q = vsync_o;
        end
        stop_run("vsync_o never fell");
    endtask

    task automatic wait_strobe(input int unsigned base);
        for (int i = 0; i < 2 * FRAME_CYCLES; i++) begin
            @(negedge clk);
            if (strobe_count != base) return;
        end
        stop_run("no bus_intr_o strobe within two frames");
    endtask

    task automatic wait_display();
        logic de_q;
        de_q = 1'b1;                // skip a run already in progress
        for (int i = 0; i < 2 * FRAME_CYCLES; i++) begin
            @(negedge clk);
            if (!de_q && dv_de_o) return;
            de_q = dv_de_o;
        end
        stop_run("dv_de_o never rose");
    endtask

    // one frame from vsync fall to vsync fall
    task automatic check_video_timing();
        int cycles, hs_run, line_de, de_lines, hs_lines;
        logic hs_q, vs_q;
        cycles = 0;
        hs_run = 0;
        line_de = 0;
        de_lines = 0;
        hs_lines = 0;
        wait_vsync_fall();
        hs_q = hsync_o;
        vs_q = 1'b0;
        forever begin
            @(negedge clk);
            cycles++;
            if (vs_q && !vsync_o) break;
            check_value("intr idle", 0, bus_intr_o);    // mask is clear
            if (dv_de_o) line_de++;
            if (hsync_o) hs_run++;
            if (hs_q && !hsync_o) begin
                check_value("hsync width", `H_SYNC, hs_run);
                hs_run = 0;
            end
            if (!hs_q && hsync_o) begin                 // line boundary
                hs_lines++;
                if (line_de != 0) begin
                    check_value("de per line", `H_VIS, line_de);
                    de_lines++;
                end
                line_de = 0;
            end
            hs_q = hsync_o;
            vs_q = vsync_o;
            if (cycles > 2 * FRAME_CYCLES) stop_run("second vsync_o fall never came");
        end
        check_value("vsync period", FRAME_CYCLES, cycles);
        check_value("lines per frame", `V_TOTAL, hs_lines);
        check_value("visible lines", `V_VIS, de_lines);
    endtask

    task automatic read_back(input addr_t start, input int count, input string test);
        logic [7:0] hi, lo;
        write_word(R_VADDR, word_t'(start));
        wait_idle();
        for (int i = 0; i < count; i++) begin
            bus_read(R_VDATA, 1'b0, hi);
            bus_read(R_VDATA, 1'b1, lo);       // steps to the next word
            wait_idle();
            check_value(test, vram_model[addr_t'(start + i)], {hi, lo});
        end
    endtask

    // pixels in raster order from the vsync fall
    task automatic check_frame_pixels();
        int n;
        rgb_t exp_rgb;
        n = 0;
        wait_vsync_fall();
        for (int i = 0; i < FRAME_CYCLES && n < FRAME_WORDS; i++) begin
            @(negedge clk);
            if (dv_de_o) begin
                exp_rgb = pal_model[vram_model[n][3:0]];
                check_value($sformatf("pixel %0d", n), exp_rgb, {red_o, green_o, blue_o});
                n++;
            end
        end
        check_value("pixel count", FRAME_WORDS, n);
    endtask

    initial begin
        addr_t start;
        word_t w;
        rgb_t c;
        logic [7:0] st;
        int unsigned base;
        reset_i       = 1'b1;
        bus_cs_n_i    = 1'b1;
        bus_rd_nwr_i  = 1'b1;
        bus_reg_num_i = '0;
        bus_bytesel_i = 1'b0;
        bus_data_i    = '0;
        for (int i = 0; i < 2**`VRAM_AW; i++) begin
            vram_model[i] = '0;
        end
        for (int i = 0; i < `PAL_N; i++) begin
            pal_model[i] = '0;
        end
        repeat (10) @(posedge clk);
        reset_i <= 1'b0;

        check_video_timing();

        // auto-increment writes from a random start, then read back
        start = addr_t'(next_word());
        write_word(R_VADDR, word_t'(start));
        wait_idle();
        for (int i = 0; i < RW_WORDS; i++) begin
            w = next_word();
            write_word(R_VDATA, w);
            wait_idle();
            vram_model[addr_t'(start + i)] = w;
        end
        read_back(start, RW_WORDS, "vram readback");

        // random palette and frame, then one frame of pixels
        for (int i = 0; i < `PAL_N; i++) begin
            c = rgb_t'(next_word());
            write_word(R_PAL, {4'(i), c});      // entry in [15:12]
            pal_model[i] = c;
        end
        write_word(R_VADDR, 16'h0000);
        wait_idle();
        for (int i = 0; i < FRAME_WORDS; i++) begin
            w = next_word();
            write_word(R_VDATA, w);
            wait_idle();
            vram_model[i] = w;
        end
        check_frame_pixels();

        // video interrupt masked in, setup away from vblank start
        wait_vsync_fall();
        bus_write(R_INT, 1'b0, 8'(1 << `VIDEO_INTR));
        bus_write(R_INT, 1'b1, 8'h03);          // drop stale pending bits
        base = strobe_count;
        wait_strobe(base);
        repeat (FRAME_CYCLES + FRAME_CYCLES / 2) @(negedge clk);
        check_value("video strobe while pending", base + 1, strobe_count);
        bus_read(R_INT, 1'b1, st);
        check_value("video pending", 1, st[`VIDEO_INTR]);
        bus_write(R_INT, 1'b1, 8'(1 << `VIDEO_INTR));
        wait_strobe(base + 1);
        bus_read(R_STAT, 1'b1, st);
        check_value("vblank at video strobe", 1, st[1]);   // v_blank in bit 1

        // masked out, status still sets
        bus_write(R_INT, 1'b0, 8'h00);
        bus_write(R_INT, 1'b1, 8'h03);
        base = strobe_count;
        repeat (FRAME_CYCLES + FRAME_CYCLES / 2) @(negedge clk);
        check_value("video masked strobes", base, strobe_count);
        bus_read(R_INT, 1'b1, st);
        check_value("video masked pending", 1, st[`VIDEO_INTR]);

        // host write during visible pixels waits for a free slot
        start = addr_t'(next_word());
        write_word(R_VADDR, word_t'(start));
        wait_idle();
        repeat (4) @(negedge clk);              // let vram_done settle
        bus_write(R_INT, 1'b1, 8'h03);
        bus_write(R_INT, 1'b0, 8'(1 << `VRAM_INTR));
        base = strobe_count;
        wait_display();
        w = next_word();
        write_word(R_VDATA, w);
        vram_model[start] = w;
        wait_idle();
        repeat (4) @(negedge clk);
        check_value("vram strobe", base + 1, strobe_count);
        bus_read(R_INT, 1'b1, st);
        check_value("vram pending", 1, st[`VRAM_INTR]);
        read_back(start, 1, "busy write readback");
        repeat (4) @(negedge clk);
        check_value("vram strobe once", base + 1, strobe_count);

        if (!xosera_top_inst.xosera_properties_inst.prop_failed) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            stop_run("a bound property on the DUT outputs failed");
        end
    end

endmodule

// ==== tb/xosera_properties.sv ====
/*
 * port-level checks, bound into xosera_top
 * hsync period check arms after the first hsync pulse following reset
 * a failing check also raises prop_failed, which the testbench watches
 */
`include "xosera_macros.svh"

module xosera_properties (
    input logic         clk,
    input logic         reset_i,
    input logic [7:0]   bus_data_o,
    input logic         bus_intr_o,
    input logic [3:0]   red_o,
    input logic [3:0]   green_o,
    input logic [3:0]   blue_o,
    input logic         hsync_o,
    input logic         vsync_o,
    input logic         dv_de_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic   prop_failed;            // sticky
    logic   hs_q;
    logic   hs_armed;               // one hsync rise seen since reset

    initial prop_failed = 1'b0;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hs_q     <= 1'b0;
            hs_armed <= 1'b0;
        end else begin
            hs_q <= hsync_o;
            if (hsync_o && !hs_q) begin
                hs_armed <= 1'b1;
            end
        end
    end

    // strobe is a single cycle
    intr_one_cycle: assert property (@(posedge clk) disable iff (reset_i)
        bus_intr_o |=> !bus_intr_o)
        else begin
            prop_failed = 1'b1;
            $error("bus_intr_o high for two cycles in a row");
        end

    black_outside_de: assert property (@(posedge clk) disable iff (reset_i)
        !dv_de_o |-> ({red_o, green_o, blue_o} == 12'h000))
        else begin
            prop_failed = 1'b1;
            $error("rgb not black while dv_de_o is low");
        end

    // previous rise exactly one line back
    hsync_period: assert property (@(posedge clk) disable iff (reset_i)
        (hs_armed && $rose(hsync_o)) |->
            ($past(hsync_o, `H_TOTAL) && !$past(hsync_o, `H_TOTAL + 1)))
        else begin
            prop_failed = 1'b1;
            $error("hsync_o rise not one line after the previous rise");
        end

    no_unknown: assert property (@(posedge clk) disable iff (reset_i)
        !$isunknown({bus_data_o, bus_intr_o, red_o, green_o, blue_o,
                     hsync_o, vsync_o, dv_de_o}))
        else begin
            prop_failed = 1'b1;
            $error("unknown value on a DUT output");
        end

endmodule

bind xosera_top xosera_properties xosera_properties_inst (
    .clk(clk), .reset_i(reset_i), .bus_data_o(bus_data_o), .bus_intr_o(bus_intr_o),
    .red_o(red_o), .green_o(green_o), .blue_o(blue_o),
    .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o)
);

// ==== design/xosera_top.sv ====
/*
 * display controller top, wiring only
 * 16x8 raster from VRAM through a 16-entry palette
 * host bus is a plain chip-select strobe, no wait states
 */

module xosera_top import xosera_pkg::*; (
    input  wire logic   clk,
    input  wire logic   reset_i,
    input  wire logic   bus_cs_n_i,
    input  wire logic   bus_rd_nwr_i,
    input  wire logic   [3:0] bus_reg_num_i,
    input  wire logic   bus_bytesel_i,
    input  wire logic   [7:0] bus_data_i,
    output logic        [7:0] bus_data_o,
    output logic        bus_intr_o,
    output logic        [3:0] red_o,
    output logic        [3:0] green_o,
    output logic        [3:0] blue_o,
    output logic        hsync_o,
    output logic        vsync_o,
    output logic        dv_de_o
);

    // host side of the arbiter
    logic   host_sel, host_wr, host_ack;
    addr_t  host_addr;
    word_t  host_wdata;
    word_t  vram_rdata;             // shared by video and host

    // video timing, before the output delay
    logic   hsync, vsync, dv_de, h_blank, v_blank;
    logic   vgen_sel;
    addr_t  vgen_addr;

    logic   pal_wr;
    color_t pal_idx;
    rgb_t   pal_rgb;

    logic   video_intr, vram_done;
    intr_t  intr_mask, intr_clear, intr_status;

    bus_regs bus_regs_inst (
        .clk, .reset_i,
        .bus_cs_n_i, .bus_rd_nwr_i, .bus_reg_num_i, .bus_bytesel_i, .bus_data_i,
        .host_ack_i(host_ack), .vram_rdata_i(vram_rdata),
        .h_blank_i(h_blank), .v_blank_i(v_blank), .intr_status_i(intr_status),
        .bus_data_o,
        .host_sel_o(host_sel), .host_wr_o(host_wr),
        .host_addr_o(host_addr), .host_wdata_o(host_wdata),
        .pal_wr_o(pal_wr), .pal_idx_o(pal_idx), .pal_rgb_o(pal_rgb),
        .intr_mask_o(intr_mask), .intr_clear_o(intr_clear), .vram_done_o(vram_done)
    );

    video_timing video_timing_inst (
        .clk, .reset_i,
        .hsync_o(hsync), .vsync_o(vsync), .dv_de_o(dv_de),
        .h_blank_o(h_blank), .v_blank_o(v_blank),
        .vgen_sel_o(vgen_sel), .vgen_addr_o(vgen_addr), .video_intr_o(video_intr)
    );

    vram_arb vram_arb_inst (
        .clk, .reset_i,
        .vgen_sel_i(vgen_sel), .vgen_addr_i(vgen_addr),
        .host_sel_i(host_sel), .host_wr_i(host_wr),
        .host_addr_i(host_addr), .host_wdata_i(host_wdata),
        .vram_rdata_o(vram_rdata), .host_ack_o(host_ack)
    );

    pixel_out pixel_out_inst (
        .clk, .reset_i,
        .hsync_i(hsync), .vsync_i(vsync), .dv_de_i(dv_de), .vram_rdata_i(vram_rdata),
        .pal_wr_i(pal_wr), .pal_idx_i(pal_idx), .pal_rgb_i(pal_rgb),
        .red_o, .green_o, .blue_o, .hsync_o, .vsync_o, .dv_de_o
    );

    intr_ctrl intr_ctrl_inst (
        .clk, .reset_i,
        .video_intr_i(video_intr), .vram_done_i(vram_done),
        .intr_mask_i(intr_mask), .intr_clear_i(intr_clear),
        .intr_status_o(intr_status), .bus_intr_o
    );

endmodule

// ==== design/intr_ctrl.sv ====
/*
 * pending interrupt status and host strobe
 * a source strobes the host only when enabled and not already pending
 * clear bits come from an INT_CTRL odd-byte write
 */
`include "xosera_macros.svh"

module intr_ctrl import xosera_pkg::*; (
    input  wire logic   clk,
    input  wire logic   reset_i,
    input  wire logic   video_intr_i,       // start of vertical blank
    input  wire logic   vram_done_i,        // host VRAM access finished
    input  wire intr_t  intr_mask_i,
    input  wire intr_t  intr_clear_i,
    output intr_t       intr_status_o,
    output logic        bus_intr_o
);

    intr_t  trigger;

    always_comb begin
        trigger              = '0;
        trigger[`VIDEO_INTR] = video_intr_i;
        trigger[`VRAM_INTR]  = vram_done_i;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            intr_status_o <= '0;
            bus_intr_o    <= 1'b0;
        end else begin
            bus_intr_o    <= |(trigger & intr_mask_i & ~intr_status_o);    // new and enabled
            intr_status_o <= (intr_status_o | trigger) & ~intr_clear_i;
        end
    end

endmodule

// ==== design/pixel_out.sv ====
/*
 * palette lookup and output stage
 * vram_rdata_i carries the fetched word one cycle after the timing counters
 * all outputs land two cycles after the counters, rgb is black outside dv_de
 */
`include "xosera_macros.svh"

module pixel_out import xosera_pkg::*; (
    input  wire logic   clk,
    input  wire logic   reset_i,
    input  wire logic   hsync_i,
    input  wire logic   vsync_i,
    input  wire logic   dv_de_i,
    input  wire word_t  vram_rdata_i,       // pixel index in [3:0]
    input  wire logic   pal_wr_i,
    input  wire color_t pal_idx_i,
    input  wire rgb_t   pal_rgb_i,
    output logic        [3:0] red_o,
    output logic        [3:0] green_o,
    output logic        [3:0] blue_o,
    output logic        hsync_o,
    output logic        vsync_o,
    output logic        dv_de_o
);

    rgb_t   pal [0:`PAL_N-1];
    logic   hsync_1;                // first delay stage, matches VRAM read
    logic   vsync_1;
    logic   dv_de_1;

    initial begin
        for (int i = 0; i < `PAL_N; i++) begin
            pal[i] = '0;            // power-up black
        end
    end

    always_ff @(posedge clk) begin
        if (pal_wr_i) begin
            pal[pal_idx_i] <= pal_rgb_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            {hsync_1, vsync_1, dv_de_1} <= '0;
            {hsync_o, vsync_o, dv_de_o} <= '0;
            {red_o, green_o, blue_o}    <= '0;
        end else begin
            hsync_1 <= hsync_i;
            vsync_1 <= vsync_i;
            dv_de_1 <= dv_de_i;
            hsync_o <= hsync_1;     // second stage, matches lookup
            vsync_o <= vsync_1;
            dv_de_o <= dv_de_1;
            if (dv_de_1) begin
                {red_o, green_o, blue_o} <= pal[color_t'(vram_rdata_i[3:0])];
            end else begin
                {red_o, green_o, blue_o} <= '0;
            end
        end
    end

endmodule

// ==== design/vram_arb.sv ====
/*
 * single-port VRAM, registered read, one access per clock
 * video fetch always wins, host waits for a free cycle
 * host request must stay up until host_ack_o, ack comes with read data
 */
`include "xosera_macros.svh"

module vram_arb import xosera_pkg::*; (
    input  wire logic   clk,
    input  wire logic   reset_i,
    input  wire logic   vgen_sel_i,         // video fetch this cycle
    input  wire addr_t  vgen_addr_i,
    input  wire logic   host_sel_i,         // host request pending
    input  wire logic   host_wr_i,
    input  wire addr_t  host_addr_i,
    input  wire word_t  host_wdata_i,
    output word_t       vram_rdata_o,
    output logic        host_ack_o
);

    localparam int VRAM_WORDS = 2 ** `VRAM_AW;

    word_t  mem [0:VRAM_WORDS-1];
    logic   host_go;                // host owns the port this cycle

    // cleared at configuration so the raster starts black
    initial begin
        for (int i = 0; i < VRAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // skip the ack cycle, request is still high there
    assign host_go = host_sel_i & ~vgen_sel_i & ~host_ack_o;

    // memory port
    always_ff @(posedge clk) begin
        if (vgen_sel_i) begin
            vram_rdata_o <= mem[vgen_addr_i];
        end else if (host_go) begin
            if (host_wr_i) begin
                mem[host_addr_i] <= host_wdata_i;
            end
            vram_rdata_o <= mem[host_addr_i];   // old data on a write
        end
    end

    // ack one cycle after the host slot
    always_ff @(posedge clk) begin
        if (reset_i) begin
            host_ack_o <= 1'b0;
        end else begin
            host_ack_o <= host_go;
        end
    end

endmodule

// ==== design/video_timing.sv ====
/*
 * raster timing, sync pulses are active high
 * counters start at the first blank line so no partial frame follows reset
 * fetch address is only meaningful while vgen_sel_o is high
 */
`include "xosera_macros.svh"

module video_timing import xosera_pkg::*; (
    input  wire logic   clk,
    input  wire logic   reset_i,
    output logic        hsync_o,
    output logic        vsync_o,
    output logic        dv_de_o,
    output logic        h_blank_o,
    output logic        v_blank_o,
    output logic        vgen_sel_o,
    output addr_t       vgen_addr_o,
    output logic        video_intr_o
);

    localparam hcount_t H_LAST    = hcount_t'(`H_TOTAL - 1);
    localparam hcount_t H_VIS_N   = hcount_t'(`H_VIS);
    localparam hcount_t HS_START  = hcount_t'(`H_VIS + `H_FRONT);
    localparam hcount_t HS_END    = hcount_t'(`H_VIS + `H_FRONT + `H_SYNC);
    localparam vcount_t V_LAST    = vcount_t'(`V_TOTAL - 1);
    localparam vcount_t V_VIS_N   = vcount_t'(`V_VIS);
    localparam vcount_t VS_START  = vcount_t'(`V_VIS + `V_FRONT);
    localparam vcount_t VS_END    = vcount_t'(`V_VIS + `V_FRONT + `V_SYNC);

    hcount_t    h_cnt;
    vcount_t    v_cnt;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_cnt        <= '0;
            v_cnt        <= V_VIS_N;    // top of vertical blank
            video_intr_o <= 1'b0;
        end else begin
            // lands on the first cycle of line V_VIS
            video_intr_o <= (h_cnt == H_LAST) && (v_cnt == V_VIS_N - 1'b1);
            if (h_cnt == H_LAST) begin
                h_cnt <= '0;
                if (v_cnt == V_LAST) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    assign h_blank_o  = (h_cnt >= H_VIS_N);
    assign v_blank_o  = (v_cnt >= V_VIS_N);
    assign hsync_o    = (h_cnt >= HS_START) && (h_cnt < HS_END);
    assign vsync_o    = (v_cnt >= VS_START) && (v_cnt < VS_END);
    assign dv_de_o    = ~h_blank_o & ~v_blank_o;
    assign vgen_sel_o = dv_de_o;        // fetch every visible pixel

    // line * H_VIS + column
    assign vgen_addr_o = addr_t'(v_cnt) * addr_t'(`H_VIS) + addr_t'(h_cnt);

endmodule

// ==== design/bus_regs.sv ====
/*
 * host register interface on an 8-bit bus with byte select
 * one access per chip-select low cycle, even byte first then odd byte
 * VRAM accesses take a variable number of clocks, busy shows in STATUS
 * bus writes and VRAM side effects are dropped while busy
 */
`include "xosera_macros.svh"

module bus_regs import xosera_pkg::*; (
    input  wire logic   clk,
    input  wire logic   reset_i,
    input  wire logic   bus_cs_n_i,         // chip select, active low
    input  wire logic   bus_rd_nwr_i,       // 1 = read
    input  wire logic   [3:0] bus_reg_num_i,
    input  wire logic   bus_bytesel_i,      // 1 = odd byte
    input  wire logic   [7:0] bus_data_i,
    input  wire logic   host_ack_i,
    input  wire word_t  vram_rdata_i,
    input  wire logic   h_blank_i,
    input  wire logic   v_blank_i,
    input  wire intr_t  intr_status_i,
    output logic        [7:0] bus_data_o,
    output logic        host_sel_o,
    output logic        host_wr_o,
    output addr_t       host_addr_o,
    output word_t       host_wdata_o,
    output logic        pal_wr_o,
    output color_t      pal_idx_o,
    output rgb_t        pal_rgb_o,
    output intr_t       intr_mask_o,
    output intr_t       intr_clear_o,
    output logic        vram_done_o
);

    host_state_e    state;
    logic           cs_n_q;             // last cycle's chip select
    logic           cs_strobe;          // first low cycle of cs
    logic           busy;
    logic           wr_go;              // accepted bus write
    logic [7:0]     hold_byte;          // even byte waiting for odd
    addr_t          vram_addr;
    word_t          rd_buf;             // VRAM read buffer
    word_t          rd_word;            // register value being read

    assign cs_strobe   = cs_n_q & ~bus_cs_n_i;
    assign busy        = (state != IDLE);
    assign wr_go       = cs_strobe & ~bus_rd_nwr_i & ~busy;
    assign host_addr_o = vram_addr;     // held stable while an access is pending

    // read-back word, byte picked at the edge
    always_comb begin
        case (bus_reg_num_i)
            4'(`REG_VRAM_ADDR): rd_word = word_t'(vram_addr);
            4'(`REG_VRAM_DATA): rd_word = rd_buf;
            4'(`REG_INT_CTRL):  rd_word = {8'(intr_mask_o), 8'(intr_status_i)};
            4'(`REG_STATUS):    rd_word = {13'h0000, busy, v_blank_i, h_blank_i};
            default:            rd_word = '0;   // palette and unused read as 0
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state        <= IDLE;
            cs_n_q       <= 1'b1;
            host_sel_o   <= 1'b0;
            host_wr_o    <= 1'b0;
            pal_wr_o     <= 1'b0;
            intr_mask_o  <= '0;
            intr_clear_o <= '0;
            vram_done_o  <= 1'b0;
            vram_addr    <= '0;
            rd_buf       <= '0;
            bus_data_o   <= '0;
        end else begin
            cs_n_q       <= bus_cs_n_i;
            pal_wr_o     <= 1'b0;       // strobes default low
            intr_clear_o <= '0;
            vram_done_o  <= 1'b0;

            // finish an outstanding VRAM access
            if (busy && host_ack_i) begin
                host_sel_o  <= 1'b0;
                vram_done_o <= 1'b1;
                state       <= IDLE;
                if (state == WAIT_RD) begin
                    rd_buf <= vram_rdata_i;
                end else begin
                    vram_addr <= vram_addr + 1'b1;  // auto-increment after write
                end
            end

            if (cs_strobe && bus_rd_nwr_i) begin
                bus_data_o <= bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];
                // odd data read steps to the next word
                if (!busy && bus_bytesel_i && bus_reg_num_i == 4'(`REG_VRAM_DATA)) begin
                    vram_addr  <= vram_addr + 1'b1;
                    host_sel_o <= 1'b1;
                    host_wr_o  <= 1'b0;
                    state      <= WAIT_RD;
                end
            end

            if (wr_go && !bus_bytesel_i && bus_reg_num_i == 4'(`REG_INT_CTRL)) begin
                intr_mask_o <= bus_data_i[`INTR_W-1:0];
            end

            if (wr_go && bus_bytesel_i) begin   // odd byte commits the word
                case (bus_reg_num_i)
                    4'(`REG_VRAM_ADDR): begin
                        vram_addr  <= addr_t'({hold_byte, bus_data_i});
                        host_sel_o <= 1'b1;
                        host_wr_o  <= 1'b0;
                        state      <= WAIT_RD;
                    end
                    4'(`REG_VRAM_DATA): begin
                        host_sel_o <= 1'b1;
                        host_wr_o  <= 1'b1;
                        state      <= WAIT_WR;
                    end
                    4'(`REG_PAL_DATA):  pal_wr_o     <= 1'b1;
                    4'(`REG_INT_CTRL):  intr_clear_o <= bus_data_i[`INTR_W-1:0];
                    default: ;                      // ignored
                endcase
            end
        end
    end

    // write payload registers
    always_ff @(posedge clk) begin
        if (wr_go) begin
            if (!bus_bytesel_i) begin
                hold_byte <= bus_data_i;
            end else begin
                host_wdata_o <= {hold_byte, bus_data_i};
                pal_idx_o    <= hold_byte[7:4];                     // entry in [15:12]
                pal_rgb_o    <= {hold_byte[3:0], bus_data_i};       // colour in [11:0]
            end
        end
    end

endmodule

// ==== design/xosera_pkg.sv ====
/*
 * common types for the display controller
 * widths follow the constants in the macros header
 */
`include "xosera_macros.svh"

package xosera_pkg;

    typedef logic [15:0]            word_t;     // VRAM / register word
    typedef logic [`VRAM_AW-1:0]    addr_t;     // VRAM word address
    typedef logic [3:0]             color_t;    // palette index
    typedef logic [11:0]            rgb_t;      // {red, green, blue} 4 bits each

    typedef logic [4:0]             hcount_t;   // 0 .. H_TOTAL-1
    typedef logic [3:0]             vcount_t;   // 0 .. V_TOTAL-1

    typedef logic [`INTR_W-1:0]     intr_t;     // one bit per source

    // host VRAM access sequencing
    typedef enum logic [1:0] {
        IDLE,                                   // no access outstanding
        WAIT_RD,                                // read issued, waiting for ack
        WAIT_WR                                 // write issued, waiting for ack
    } host_state_e;

endpackage

// ==== design/xosera_macros.svh ====
/*
 * shared constants for the reduced display controller
 * raster is tiny (16x8 visible) so a frame is only 288 clocks
 * register numbers are 4-bit bus values, interrupt bits index intr_t
 */
`ifndef XOSERA_MACROS_SVH
`define XOSERA_MACROS_SVH

`define H_VIS           16      // visible pixels per line
`define H_FRONT         2       // front porch clocks
`define H_SYNC          3       // hsync width, clocks
`define H_TOTAL         24      // clocks per line
`define V_VIS           8       // visible lines per frame
`define V_FRONT         1       // front porch lines
`define V_SYNC          1       // vsync width, lines
`define V_TOTAL         12      // lines per frame

`define VRAM_AW         8       // 256 words of VRAM
`define PAL_N           16      // palette entries

`define REG_VRAM_ADDR   0
`define REG_VRAM_DATA   1
`define REG_PAL_DATA    2
`define REG_INT_CTRL    3
`define REG_STATUS      4

`define INTR_W          2       // interrupt vector width
`define VIDEO_INTR      0       // start of vertical blank
`define VRAM_INTR       1       // host VRAM access done

`endif
